// ==== verilog/div_pkg.sv ====
// shared widths, latency and payload types for the pipelined divider, imported by every block
`default_nettype none

package div_pkg;

   // operand and pipeline geometry
   localparam int DIV_W   = 16;
   localparam int STAGES  = DIV_W;
   // input stage + one clock per stage + output stage
   localparam int LATENCY = STAGES + 2;

   // rate value + 1 is the minimum spacing of accepted starts in clocks
   localparam int RATE_W  = 2;
   localparam int TAG_W   = 4;

   typedef logic [TAG_W-1:0] div_tag_t;

   typedef struct packed {
      logic [DIV_W-1:0] dividend;
      logic [DIV_W-1:0] divisor;
      logic             sgn;
      div_tag_t         tag;
   } div_req_t;

   // working word between stages
   typedef struct packed {
      // signed partial remainder, one guard bit
      logic [DIV_W:0]   rem;
      // dividend bits shift out at the top, quotient bits shift in at the bottom
      logic [DIV_W-1:0] quo;
      logic [DIV_W-1:0] dvs;
   } div_part_t;

   typedef struct packed {
      logic             quo_neg;
      logic             rem_neg;
      logic             dbz;
      logic [DIV_W-1:0] dividend;
   } div_side_t;

   typedef struct packed {
      logic [DIV_W-1:0] quo;
      logic [DIV_W-1:0] rem;
      div_tag_t         tag;
      logic             dbz;
   } div_res_t;

   typedef enum logic [1:0] {
      ST_READY,
      ST_SPACING,
      ST_DROP_FLAG
   } div_ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/div_rate_counter.sv ====
// interval counter for the divider issue logic, restarted on every accepted operation
`default_nettype none

module div_rate_counter (
   input  wire logic                      C,
   input  wire logic                      rst,
   input  wire logic                      restart,
   input  wire logic [div_pkg::RATE_W-1:0] rate,
   output logic                           elapsed
);
   import div_pkg::*;

   logic [RATE_W-1:0] cnt;

   // loads rate, then counts down and parks at zero
   always_ff @(posedge C) begin
      if (rst) begin
         cnt <= '0;
      end else if (restart) begin
         cnt <= rate;
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign elapsed = (cnt == '0);

   // controller may only restart once the previous interval ran out
   a_no_early_restart: assert property (
      @(posedge C) disable iff (rst)
      restart |-> cnt == '0
   );

endmodule

`default_nettype wire

// ==== verilog/div_issue_ctrl.sv ====
// start acceptance FSM for the divider, drops starts that come too early and flags overrun
`default_nettype none

module div_issue_ctrl (
   input  wire logic C,
   input  wire logic rst,
   input  wire logic start,
   input  wire logic elapsed,
   output logic      accept,
   output logic      restart,
   output logic      overrun
);
   import div_pkg::*;

   div_ctrl_state_t state;
   div_ctrl_state_t state_nxt;

   // READY takes a start at once, otherwise wait for the counter
   assign accept  = start & ((state == ST_READY) | elapsed);
   assign restart = accept;

   // one clock after a dropped start
   assign overrun = (state == ST_DROP_FLAG);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_READY: begin
            if (start) begin
               state_nxt = ST_SPACING;
            end
         end
         ST_SPACING, ST_DROP_FLAG: begin
            if (start && elapsed) begin
               // back to back accept, new interval
               state_nxt = ST_SPACING;
            end else if (start) begin
               state_nxt = ST_DROP_FLAG;
            end else if (elapsed) begin
               state_nxt = ST_READY;
            end else begin
               state_nxt = ST_SPACING;
            end
         end
         default: begin
            state_nxt = ST_READY;
         end
      endcase
   end

   always_ff @(posedge C) begin
      if (rst) begin
         state <= ST_READY;
      end else begin
         state <= state_nxt;
      end
   end

   // READY must only be held while the counter is idle
   a_accept_outside_interval: assert property (
      @(posedge C) disable iff (rst)
      accept |-> elapsed
   );

   a_ready_idle: assert property (
      @(posedge C) disable iff (rst)
      (state == ST_READY) |-> elapsed
   );

endmodule

`default_nettype wire

// ==== verilog/div_sign_in.sv ====
// divider input stage: operand magnitudes, sign and zero flags, first partial word
`default_nettype none

module div_sign_in (
   input  wire logic              C,
   input  wire logic              rst,
   input  wire logic              accept,
   input  wire div_pkg::div_req_t req,
   output div_pkg::div_part_t     part,
   output logic                   part_vld,
   output div_pkg::div_side_t     side,
   output div_pkg::div_tag_t      tag
);
   import div_pkg::*;

   logic             a_neg;
   logic             b_neg;
   logic [DIV_W-1:0] a_mag;
   logic [DIV_W-1:0] b_mag;

   // sign bits only count in signed mode
   assign a_neg = req.sgn & req.dividend[DIV_W-1];
   assign b_neg = req.sgn & req.divisor[DIV_W-1];

   // most negative value maps onto itself, fine as an unsigned magnitude
   assign a_mag = a_neg ? (~req.dividend + 1'b1) : req.dividend;
   assign b_mag = b_neg ? (~req.divisor + 1'b1) : req.divisor;

   always_ff @(posedge C) begin
      if (rst) begin
         part_vld <= 1'b0;
      end else begin
         part_vld <= accept;
      end
   end

   // payload only moves on accept
   always_ff @(posedge C) begin
      if (accept) begin
         part.rem      <= '0;
         part.quo      <= a_mag;
         part.dvs      <= b_mag;
         side.quo_neg  <= a_neg ^ b_neg;
         side.rem_neg  <= a_neg;
         side.dbz      <= (req.divisor == '0);
         side.dividend <= req.dividend;
         tag           <= req.tag;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/div_nr_stage.sv ====
// one non-restoring divider step, instantiated once per quotient bit
`default_nettype none

module div_nr_stage (
   input  wire logic               C,
   input  wire logic               rst,
   input  wire logic               in_vld,
   input  wire div_pkg::div_part_t part_in,
   output logic                    out_vld,
   output div_pkg::div_part_t      part_out
);
   import div_pkg::*;

   logic           rem_neg;
   logic [DIV_W:0] rem_sh;
   logic [DIV_W:0] rem_nxt;

   // add or subtract is chosen by the sign before the shift
   assign rem_neg = part_in.rem[DIV_W];

   // next dividend bit enters at the bottom
   assign rem_sh = {part_in.rem[DIV_W-1:0], part_in.quo[DIV_W-1]};

   // wraps modulo 2**(DIV_W+1), true result always fits
   assign rem_nxt = rem_neg ? (rem_sh + {1'b0, part_in.dvs})
                            : (rem_sh - {1'b0, part_in.dvs});

   always_ff @(posedge C) begin
      if (rst) begin
         out_vld <= 1'b0;
      end else begin
         out_vld <= in_vld;
      end
   end

   always_ff @(posedge C) begin
      part_out.rem <= rem_nxt;
      part_out.quo <= {part_in.quo[DIV_W-2:0], ~rem_nxt[DIV_W]};
      part_out.dvs <= part_in.dvs;
   end

   a_vld_known: assert property (
      @(posedge C) disable iff (rst)
      !$isunknown(out_vld)
   );

endmodule

`default_nettype wire

// ==== verilog/div_side_pipe.sv ====
// delay line that keeps per-operation payload in step with the divider stages
`default_nettype none

module div_side_pipe #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 1
) (
   input  wire logic     C,
   input  wire logic     rst,
   input  wire logic     in_vld,
   input  wire payload_t din,
   output logic          out_vld,
   output payload_t      dout
);

   logic     vld [DEPTH];
   payload_t data [DEPTH];

   always_ff @(posedge C) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            vld[i] <= 1'b0;
         end
      end else begin
         vld[0] <= in_vld;
         for (int i = 1; i < DEPTH; i++) begin
            vld[i] <= vld[i-1];
         end
      end
   end

   always_ff @(posedge C) begin
      data[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
         data[i] <= data[i-1];
      end
   end

   assign out_vld = vld[DEPTH-1];
   assign dout    = data[DEPTH-1];

endmodule

`default_nettype wire

// ==== verilog/div_sign_out.sv ====
// divider output stage: remainder fix-up, sign restore, divide-by-zero result
`default_nettype none

module div_sign_out (
   input  wire logic               C,
   input  wire logic               rst,
   input  wire logic               part_vld,
   input  wire div_pkg::div_part_t part,
   input  wire logic               side_vld,
   input  wire div_pkg::div_side_t side,
   input  wire div_pkg::div_tag_t  tag,
   output logic                    res_vld,
   output div_pkg::div_res_t       res
);
   import div_pkg::*;

   logic [DIV_W:0]   rem_fix;
   logic [DIV_W-1:0] rem_mag;
   logic [DIV_W-1:0] quo_sgn;
   logic [DIV_W-1:0] rem_sgn;

   // negative final remainder still owes one divisor
   assign rem_fix = part.rem[DIV_W] ? (part.rem + {1'b0, part.dvs}) : part.rem;
   assign rem_mag = rem_fix[DIV_W-1:0];

   assign quo_sgn = side.quo_neg ? (~part.quo + 1'b1) : part.quo;
   assign rem_sgn = side.rem_neg ? (~rem_mag + 1'b1) : rem_mag;

   always_ff @(posedge C) begin
      if (rst) begin
         res_vld <= 1'b0;
      end else begin
         res_vld <= part_vld;
      end
   end

   always_ff @(posedge C) begin
      res.tag <= tag;
      res.dbz <= side.dbz;
      if (side.dbz) begin
         // all ones quotient, dividend passed back unchanged
         res.quo <= '1;
         res.rem <= side.dividend;
      end else begin
         res.quo <= quo_sgn;
         res.rem <= rem_sgn;
      end
   end

   // stage chain and side pipe must stay aligned
   a_vld_align: assert property (
      @(posedge C) disable iff (rst)
      part_vld == side_vld
   );

   a_rem_range: assert property (
      @(posedge C) disable iff (rst)
      (part_vld && !side.dbz) |-> (rem_fix[DIV_W] == 1'b0) && (rem_mag < part.dvs)
   );

endmodule

`default_nettype wire

// ==== verilog/div_top.sv ====
// pipelined 16-bit divider top, start strobe in, result strobe out LATENCY clocks later
`default_nettype none

module div_top (
   input  wire logic                       C,
   input  wire logic                       rst,
   input  wire logic                       start,
   input  wire div_pkg::div_req_t          req,
   input  wire logic [div_pkg::RATE_W-1:0] rate,
   output logic                            res_vld,
   output div_pkg::div_res_t               res,
   output logic                            overrun
);
   import div_pkg::*;

   logic      accept;
   logic      restart;
   logic      elapsed;

   // index 0 is the input stage, STAGES the last step
   logic      stg_vld  [STAGES+1];
   div_part_t stg_part [STAGES+1];

   div_side_t side_in;
   div_side_t side_out;
   logic      side_vld;
   div_tag_t  tag_in;
   div_tag_t  tag_out;

   div_issue_ctrl u_ctrl (
      .C       (C),
      .rst     (rst),
      .start   (start),
      .elapsed (elapsed),
      .accept  (accept),
      .restart (restart),
      .overrun (overrun)
   );

   div_rate_counter u_rate (
      .C       (C),
      .rst     (rst),
      .restart (restart),
      .rate    (rate),
      .elapsed (elapsed)
   );

   div_sign_in u_sign_in (
      .C        (C),
      .rst      (rst),
      .accept   (accept),
      .req      (req),
      .part     (stg_part[0]),
      .part_vld (stg_vld[0]),
      .side     (side_in),
      .tag      (tag_in)
   );

   // one quotient bit per stage, msb first
   for (genvar i = 0; i < STAGES; i++) begin : g_stage
      div_nr_stage u_stage (
         .C        (C),
         .rst      (rst),
         .in_vld   (stg_vld[i]),
         .part_in  (stg_part[i]),
         .out_vld  (stg_vld[i+1]),
         .part_out (stg_part[i+1])
      );
   end

   div_side_pipe #(
      .payload_t (div_side_t),
      .DEPTH     (STAGES)
   ) u_side_pipe (
      .C       (C),
      .rst     (rst),
      .in_vld  (stg_vld[0]),
      .din     (side_in),
      .out_vld (side_vld),
      .dout    (side_out)
   );

   // tag slots follow the same valid chain, its copy is not needed
   div_side_pipe #(
      .payload_t (div_tag_t),
      .DEPTH     (STAGES)
   ) u_tag_pipe (
      .C       (C),
      .rst     (rst),
      .in_vld  (stg_vld[0]),
      .din     (tag_in),
      .out_vld (),
      .dout    (tag_out)
   );

   div_sign_out u_sign_out (
      .C        (C),
      .rst      (rst),
      .part_vld (stg_vld[STAGES]),
      .part     (stg_part[STAGES]),
      .side_vld (side_vld),
      .side     (side_out),
      .tag      (tag_out),
      .res_vld  (res_vld),
      .res      (res)
   );

endmodule

`default_nettype wire

// ==== dv/div_tb.sv ====
// directed testbench for div_top, checks results, latency, tags and overrun against a model
`default_nettype none

module div_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import div_pkg::*;

   localparam int SINGLE_OPS  = 21;
   localparam int STREAM_OPS  = 40;
   localparam int RATE_STARTS = 24;
   // issue, drain and idle clocks of one test step
   localparam int OP_SPAN     = LATENCY + 8;
   localparam int TIMEOUT_CYC = 2 * (4 + SINGLE_OPS * OP_SPAN + (STREAM_OPS + OP_SPAN)
                                     + (RATE_STARTS + OP_SPAN));

   logic              C;
   logic              rst;
   logic              start;
   div_req_t          req;
   logic [RATE_W-1:0] rate;
   logic              res_vld;
   div_res_t          res;
   logic              overrun;

   int          cyc;
   int          next_ok;
   int          errors;
   int          checks;
   int          seed;
   logic        checking;
   div_tag_t    tag_ctr;

   // expected results with their start clock, expected overrun clocks
   div_res_t    exp_q[$];
   int          acc_q[$];
   int          ovr_q[$];

   div_res_t    mon_exp;
   int          mon_cyc;
   logic        mon_ovr;

   div_top dut0 (
      .C       (C),
      .rst     (rst),
      .start   (start),
      .req     (req),
      .rate    (rate),
      .res_vld (res_vld),
      .res     (res),
      .overrun (overrun)
   );

   initial begin
      C = 1'b0;
      forever #50 C = ~C;
   end

   always @(posedge C) begin
      cyc = cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         $display("timeout: run did not finish within %0d clocks", TIMEOUT_CYC);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // truncating division, remainder follows the dividend
   function automatic div_res_t model(input div_req_t r);
      div_res_t e;
      int       a;
      int       b;
      int       q;
      int       m;
      e.tag = r.tag;
      e.dbz = (r.divisor == '0);
      if (e.dbz) begin
         e.quo = '1;
         e.rem = r.dividend;
      end else begin
         if (r.sgn) begin
            a = $signed(r.dividend);
            b = $signed(r.divisor);
         end else begin
            a = {16'h0, r.dividend};
            b = {16'h0, r.divisor};
         end
         q = a / b;
         m = a % b;
         e.quo = q[DIV_W-1:0];
         e.rem = m[DIV_W-1:0];
      end
      return e;
   endfunction

   function automatic div_req_t make_req(input logic [DIV_W-1:0] a,
                                         input logic [DIV_W-1:0] b, input logic sgn);
      div_req_t r;
      r.dividend = a;
      r.divisor  = b;
      r.sgn      = sgn;
      r.tag      = tag_ctr;
      tag_ctr    = tag_ctr + 1'b1;
      return r;
   endfunction

   function automatic div_req_t rand_req();
      logic [31:0] v;
      logic [DIV_W-1:0] b;
      v = $random(seed);
      b = v[31:16];
      // small divisors now and then, zero included
      if (v[2]) begin
         b = {12'h0, v[31:28]};
      end
      return make_req(v[15:0], b, v[0]);
   endfunction

   // predicts acceptance from the spacing rule
   task automatic drive_start(input div_req_t r);
      @(negedge C);
      start = 1'b1;
      req   = r;
      if (cyc >= next_ok) begin
         exp_q.push_back(model(r));
         acc_q.push_back(cyc);
         next_ok = cyc + rate + 1;
      end else begin
         ovr_q.push_back(cyc + 1);
      end
   endtask

   task automatic drain_results();
      int waited;
      @(negedge C);
      start  = 1'b0;
      waited = 0;
      while ((exp_q.size() != 0 || ovr_q.size() != 0) && waited < LATENCY + 4) begin
         @(negedge C);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("result strobe missing for %0d accepted operations", exp_q.size());
         errors += exp_q.size();
         exp_q.delete();
         acc_q.delete();
      end
      if (ovr_q.size() != 0) begin
         $display("overrun pulse missing for %0d dropped starts", ovr_q.size());
         errors += ovr_q.size();
         ovr_q.delete();
      end
      repeat (2) @(negedge C);
   endtask

   task automatic run_single(input logic [DIV_W-1:0] a, input logic [DIV_W-1:0] b,
                             input logic sgn);
      drive_start(make_req(a, b, sgn));
      drain_results();
   endtask

   task automatic report_test(input string name, input int err0);
      $display("test %s finished with %0d errors", name, errors - err0);
   endtask

   task automatic test_unsigned();
      int err0;
      err0 = errors;
      run_single(16'd100, 16'd7, 1'b0);
      run_single(16'h1234, 16'h0001, 1'b0);
      run_single(16'd5, 16'd9, 1'b0);
      run_single(16'hffff, 16'hffff, 1'b0);
      run_single(16'hffff, 16'h0001, 1'b0);
      run_single(16'hffff, 16'h0002, 1'b0);
      run_single(16'h0000, 16'h0003, 1'b0);
      run_single(16'h8000, 16'h7fff, 1'b0);
      report_test("unsigned", err0);
   endtask

   task automatic test_signed();
      int err0;
      err0 = errors;
      run_single(16'd100, 16'd7, 1'b1);
      run_single(-16'sd100, 16'd7, 1'b1);
      run_single(16'd100, -16'sd7, 1'b1);
      run_single(-16'sd100, -16'sd7, 1'b1);
      run_single(16'h8000, 16'h0001, 1'b1);
      run_single(16'h8000, 16'hffff, 1'b1);
      run_single(16'h8000, 16'h0007, 1'b1);
      run_single(16'h7fff, 16'h8000, 1'b1);
      run_single(16'hffff, 16'h0005, 1'b1);
      report_test("signed", err0);
   endtask

   task automatic test_div_zero();
      int err0;
      err0 = errors;
      run_single(16'h1234, 16'h0000, 1'b0);
      run_single(16'h0000, 16'h0000, 1'b0);
      run_single(16'h8000, 16'h0000, 1'b1);
      run_single(16'hffff, 16'h0000, 1'b1);
      report_test("div_zero", err0);
   endtask

   task automatic test_stream();
      int err0;
      err0 = errors;
      for (int i = 0; i < STREAM_OPS; i++) begin
         drive_start(rand_req());
      end
      drain_results();
      report_test("stream_rate0", err0);
   endtask

   task automatic test_rate_limit();
      int err0;
      err0 = errors;
      @(negedge C);
      rate = 2'd3;
      for (int i = 0; i < RATE_STARTS; i++) begin
         drive_start(rand_req());
      end
      drain_results();
      rate = 2'd0;
      report_test("rate3_overrun", err0);
   endtask

   // results and overrun sampled between clock edges
   always @(negedge C) begin
      if (checking) begin
         if (res_vld) begin
            if (exp_q.size() == 0) begin
               $display("result strobe seen with no operation in flight");
               errors++;
            end else begin
               mon_exp = exp_q.pop_front();
               mon_cyc = acc_q.pop_front();
               check_val("res.quo", res.quo, mon_exp.quo);
               check_val("res.rem", res.rem, mon_exp.rem);
               check_val("res.tag", res.tag, mon_exp.tag);
               check_val("res.dbz", res.dbz, mon_exp.dbz);
               check_val("latency", cyc - mon_cyc, LATENCY);
            end
         end
         mon_ovr = (ovr_q.size() != 0) && (ovr_q[0] == cyc);
         if (mon_ovr) begin
            void'(ovr_q.pop_front());
         end
         check_val("overrun", overrun, mon_ovr);
      end
   end

   initial begin
      rst      = 1'b1;
      start    = 1'b0;
      req      = '0;
      rate     = '0;
      cyc      = 0;
      next_ok  = 0;
      errors   = 0;
      checks   = 0;
      seed     = 32'h16a592ae;
      checking = 1'b0;
      tag_ctr  = '0;
      repeat (4) @(posedge C);
      @(negedge C);
      rst = 1'b0;
      check_val("res_vld", res_vld, 1'b0);
      checking = 1'b1;
      test_unsigned();
      test_signed();
      test_div_zero();
      test_stream();
      test_rate_limit();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/div_pkg.sv
verilog/div_rate_counter.sv
verilog/div_issue_ctrl.sv
verilog/div_sign_in.sv
verilog/div_nr_stage.sv
verilog/div_side_pipe.sv
verilog/div_sign_out.sv
verilog/div_top.sv
dv/div_tb.sv
